// ==== logic/fpu_pkg.sv ====
package fpu_pkg;

	localparam int SIGN_BIT = 31;
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX = 255;
	localparam int MANT_WIDTH = 24; // hidden bit included.
	localparam int ADD_WIDTH = MANT_WIDTH + 3; // three guard bits under the mantissa.

	typedef logic [SIGN_BIT:0] float_t;
	typedef logic [7:0] exponent_t;
	typedef logic [MANT_WIDTH-1:0] mantissa_t;

	typedef enum logic [4:0] {
		FPU_OP_ADD = 5'd0,
		FPU_OP_SUB = 5'd1,
		FPU_OP_MUL = 5'd2,
		FPU_OP_MOV = 5'd3,
		FPU_OP_CMP_EQUAL = 5'd4,
		FPU_OP_CMP_LESS = 5'd5,
		FPU_OP_CMP_LEQUAL = 5'd6,
		FPU_OP_SGNJ = 5'd7,
		FPU_OP_SGNJN = 5'd8,
		FPU_OP_SGNJX = 5'd9,
		FPU_OP_MIN = 5'd10,
		FPU_OP_MAX = 5'd11
	} fpu_op_t;

	typedef enum logic [2:0] {
		ADD_IDLE,
		ADD_UNPACK,
		ADD_ALIGN,
		ADD_ADD,
		ADD_NORMALIZE,
		ADD_DONE
	} add_state_t;

	typedef enum logic [2:0] {
		MUL_IDLE,
		MUL_UNPACK,
		MUL_MULTIPLY,
		MUL_NORMALIZE,
		MUL_DONE
	} mul_state_t;

	function automatic exponent_t get_exponent(float_t value);
		return value[SIGN_BIT-1 -: 8];
	endfunction

	// a zero exponent is only ever a zero here, so it has no hidden bit.
	function automatic mantissa_t get_mantissa(float_t value);
		return {value[SIGN_BIT-1 -: 8] != 8'd0, value[MANT_WIDTH-2:0]};
	endfunction

endpackage

// ==== logic/fpu_add.sv ====
module fpu_add import fpu_pkg::*; (
	input  logic   i_clock,
	input  logic   i_reset,
	input  logic   i_request,
	input  float_t i_op1,
	input  float_t i_op2,
	output logic   o_ready,
	output float_t o_result
);

	add_state_t state;

	logic sign_a;
	logic sign_b;
	logic sign_r;
	exponent_t exp_a;
	exponent_t exp_b;
	exponent_t exp_r;
	logic [ADD_WIDTH-1:0] mant_a;
	logic [ADD_WIDTH-1:0] mant_b;
	logic [ADD_WIDTH:0] sum; // top bit catches the carry of an add.

	assign o_ready = (state == ADD_DONE);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ADD_IDLE;
		end else begin
			case (state)
				ADD_IDLE: begin
					if (i_request) begin
						state <= ADD_UNPACK;
					end
				end

				ADD_UNPACK: begin
					sign_a <= i_op1[SIGN_BIT];
					sign_b <= i_op2[SIGN_BIT];
					exp_a <= get_exponent(i_op1);
					exp_b <= get_exponent(i_op2);
					mant_a <= {get_mantissa(i_op1), 3'b000};
					mant_b <= {get_mantissa(i_op2), 3'b000};
					state <= ADD_ALIGN;
				end

				// the smaller operand is shifted in one go, bits past the guard bits are lost.
				ADD_ALIGN: begin
					if (exp_a >= exp_b) begin
						mant_b <= mant_b >> (exp_a - exp_b);
						exp_r <= exp_a;
					end else begin
						mant_a <= mant_a >> (exp_b - exp_a);
						exp_r <= exp_b;
					end
					state <= ADD_ADD;
				end

				ADD_ADD: begin
					if (sign_a == sign_b) begin
						sum <= {1'b0, mant_a} + {1'b0, mant_b};
						sign_r <= sign_a;
					end else if (mant_a >= mant_b) begin
						sum <= {1'b0, mant_a - mant_b};
						sign_r <= sign_a;
					end else begin
						sum <= {1'b0, mant_b - mant_a};
						sign_r <= sign_b;
					end
					state <= ADD_NORMALIZE;
				end

				// shifts left one bit per cycle until the hidden bit is in place.
				ADD_NORMALIZE: begin
					if (sum == '0) begin
						o_result <= '0; // exact cancellation packs as +0.
						state <= ADD_DONE;
					end else if (sum[ADD_WIDTH]) begin
						o_result <= {sign_r, exp_r + 8'd1, sum[ADD_WIDTH-1 -: MANT_WIDTH-1]};
						state <= ADD_DONE;
					end else if (sum[ADD_WIDTH-1]) begin
						o_result <= {sign_r, exp_r, sum[ADD_WIDTH-2 -: MANT_WIDTH-1]};
						state <= ADD_DONE;
					end else if (exp_r <= 8'd1) begin
						o_result <= '0; // would go denormal.
						state <= ADD_DONE;
					end else begin
						sum <= sum << 1;
						exp_r <= exp_r - 8'd1;
					end
				end

				ADD_DONE: begin
					if (!i_request) begin
						state <= ADD_IDLE;
					end
				end

				default: begin
					state <= ADD_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== logic/fpu_mul.sv ====
module fpu_mul import fpu_pkg::*; (
	input  logic   i_clock,
	input  logic   i_reset,
	input  logic   i_request,
	input  float_t i_op1,
	input  float_t i_op2,
	output logic   o_ready,
	output float_t o_result
);

	mul_state_t state;

	logic sign_r;
	logic zero_in;
	mantissa_t mant_a;
	mantissa_t mant_b;
	logic signed [9:0] exp_sum; // room for the sign and the overflow of two exponents.
	logic signed [9:0] exp_norm;
	logic [2*MANT_WIDTH-1:0] product;

	// a product of two normal mantissas lies in [1, 4), so one bit of shift is enough.
	assign exp_norm = exp_sum + (product[2*MANT_WIDTH-1] ? 10'sd1 : 10'sd0);
	assign o_ready = (state == MUL_DONE);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= MUL_IDLE;
		end else begin
			case (state)
				MUL_IDLE: begin
					if (i_request) begin
						state <= MUL_UNPACK;
					end
				end

				MUL_UNPACK: begin
					sign_r <= i_op1[SIGN_BIT] ^ i_op2[SIGN_BIT];
					zero_in <= (get_exponent(i_op1) == '0) || (get_exponent(i_op2) == '0);
					exp_sum <= 10'(int'(get_exponent(i_op1)) + int'(get_exponent(i_op2)) - EXP_BIAS);
					mant_a <= get_mantissa(i_op1);
					mant_b <= get_mantissa(i_op2);
					state <= MUL_MULTIPLY;
				end

				MUL_MULTIPLY: begin
					product <= mant_a * mant_b;
					state <= MUL_NORMALIZE;
				end

				MUL_NORMALIZE: begin
					if (zero_in || exp_norm <= 0) begin
						o_result <= '0;
					end else if (exp_norm >= EXP_MAX) begin
						// no infinity, overflow saturates at the largest finite value.
						o_result <= {sign_r, exponent_t'(EXP_MAX - 1), {(MANT_WIDTH-1){1'b1}}};
					end else if (product[2*MANT_WIDTH-1]) begin
						o_result <= {sign_r, exponent_t'(exp_norm),
							product[2*MANT_WIDTH-2 -: MANT_WIDTH-1]};
					end else begin
						o_result <= {sign_r, exponent_t'(exp_norm),
							product[2*MANT_WIDTH-3 -: MANT_WIDTH-1]};
					end
					state <= MUL_DONE;
				end

				MUL_DONE: begin
					if (!i_request) begin
						state <= MUL_IDLE;
					end
				end

				default: begin
					state <= MUL_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== logic/fpu.sv ====
module fpu import fpu_pkg::*; (
	input  logic    i_clock,
	input  logic    i_reset,
	input  logic    i_request,
	input  fpu_op_t i_op,
	input  float_t  i_op1,
	input  float_t  i_op2,
	output logic    o_ready,
	output float_t  o_result
);

	logic add_request;
	logic add_ready;
	float_t add_result;
	logic sub_request;
	logic sub_ready;
	float_t sub_result;
	logic mul_request;
	logic mul_ready;
	float_t mul_result;
	float_t neg_op2;
	logic cmp_equal;
	logic cmp_less;
	logic sel_ready;

	assign add_request = i_request && (i_op == FPU_OP_ADD);
	assign mul_request = i_request && (i_op == FPU_OP_MUL);

	// compares and min/max all look at op1 - op2.
	assign sub_request = i_request && (i_op inside {FPU_OP_SUB, FPU_OP_CMP_EQUAL,
		FPU_OP_CMP_LESS, FPU_OP_CMP_LEQUAL, FPU_OP_MIN, FPU_OP_MAX});
	assign neg_op2 = {~i_op2[SIGN_BIT], i_op2[SIGN_BIT-1:0]};

	fpu_add u_add (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(add_request),
		.i_op1(i_op1),
		.i_op2(i_op2),
		.o_ready(add_ready),
		.o_result(add_result)
	);

	fpu_add u_sub (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(sub_request),
		.i_op1(i_op1),
		.i_op2(neg_op2),
		.o_ready(sub_ready),
		.o_result(sub_result)
	);

	fpu_mul u_mul (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(mul_request),
		.i_op1(i_op1),
		.i_op2(i_op2),
		.o_ready(mul_ready),
		.o_result(mul_result)
	);

	assign cmp_equal = (sub_result[SIGN_BIT-1:0] == '0); // +0 and -0 both count.
	assign cmp_less = sub_result[SIGN_BIT];

	always_comb begin
		case (i_op)
			FPU_OP_ADD: sel_ready = add_ready;
			FPU_OP_SUB, FPU_OP_CMP_EQUAL, FPU_OP_CMP_LESS, FPU_OP_CMP_LEQUAL,
			FPU_OP_MIN, FPU_OP_MAX: sel_ready = sub_ready;
			FPU_OP_MUL: sel_ready = mul_ready;
			FPU_OP_MOV, FPU_OP_SGNJ, FPU_OP_SGNJN, FPU_OP_SGNJX: sel_ready = 1'b1;
			default: sel_ready = 1'b0;
		endcase
	end

	assign o_ready = i_request & sel_ready;

	always_comb begin
		case (i_op)
			FPU_OP_ADD: o_result = add_result;
			FPU_OP_SUB: o_result = sub_result;
			FPU_OP_MUL: o_result = mul_result;
			FPU_OP_MOV: o_result = i_op1;
			FPU_OP_CMP_EQUAL: o_result = {{SIGN_BIT{1'b0}}, cmp_equal};
			FPU_OP_CMP_LESS: o_result = {{SIGN_BIT{1'b0}}, cmp_less};
			FPU_OP_CMP_LEQUAL: o_result = {{SIGN_BIT{1'b0}}, cmp_equal | cmp_less};
			FPU_OP_SGNJ: o_result = {i_op2[SIGN_BIT], i_op1[SIGN_BIT-1:0]};
			FPU_OP_SGNJN: o_result = {~i_op2[SIGN_BIT], i_op1[SIGN_BIT-1:0]};
			FPU_OP_SGNJX: o_result = {i_op1[SIGN_BIT] ^ i_op2[SIGN_BIT], i_op1[SIGN_BIT-1:0]};
			FPU_OP_MIN: o_result = sub_result[SIGN_BIT] ? i_op1 : i_op2;
			FPU_OP_MAX: o_result = sub_result[SIGN_BIT] ? i_op2 : i_op1;
			default: o_result = '0;
		endcase
	end

endmodule

// ==== tests/fpu_asserts.sv ====
module fpu_asserts import fpu_pkg::*; (
	input logic   i_clock,
	input logic   i_reset,
	input logic   i_request,
	input logic   i_ready,
	input float_t i_result,
	input logic   i_add_request,
	input logic   i_add_ready,
	input logic   i_sub_request,
	input logic   i_sub_ready,
	input logic   i_mul_request,
	input logic   i_mul_ready
);

	int fail_count = 0; // read by the testbench at the end of the run.

	// every state machine comes out of reset idle.
	ready_low_after_reset: assert property (
		@(posedge i_clock) i_reset |=> !(i_add_ready || i_sub_ready || i_mul_ready)
	) else begin
		fail_count++;
		$error("a unit ready is high right after reset");
	end

	add_idle_after_drop: assert property (
		@(posedge i_clock) disable iff (i_reset) !i_add_request |=> !i_add_ready
	) else begin
		fail_count++;
		$error("the add unit kept ready high after its request dropped");
	end

	sub_idle_after_drop: assert property (
		@(posedge i_clock) disable iff (i_reset) !i_sub_request |=> !i_sub_ready
	) else begin
		fail_count++;
		$error("the subtract unit kept ready high after its request dropped");
	end

	mul_idle_after_drop: assert property (
		@(posedge i_clock) disable iff (i_reset) !i_mul_request |=> !i_mul_ready
	) else begin
		fail_count++;
		$error("the multiply unit kept ready high after its request dropped");
	end

	// a held request keeps the finished result on the port.
	result_stable_while_held: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(i_ready && i_request) ##1 i_request |-> $stable(i_result)
	) else begin
		fail_count++;
		$error("o_result changed while ready was held");
	end

endmodule

// ==== tests/fpu_tb.sv ====
module fpu_tb import fpu_pkg::*; ();

	localparam int MAX_CASES = 64;
	localparam int READY_TIMEOUT = 100; // a cycle count well above the longest normalize.
	localparam int DRIVE_DELAY = 1;

	logic clock;
	logic reset;
	logic request;
	fpu_op_t op;
	float_t op1;
	float_t op2;
	logic ready;
	float_t result;

	// each case takes four words in the order op code, operand 1, operand 2 and expected result.
	logic [31:0] case_words [0:4*MAX_CASES-1];
	int case_count;

	fpu u_fpu (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_op(op),
		.i_op1(op1),
		.i_op2(op2),
		.o_ready(ready),
		.o_result(result)
	);

	bind fpu fpu_asserts u_fpu_asserts (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_ready(o_ready),
		.i_result(o_result),
		.i_add_request(add_request),
		.i_add_ready(add_ready),
		.i_sub_request(sub_request),
		.i_sub_ready(sub_ready),
		.i_mul_request(mul_request),
		.i_mul_ready(mul_ready)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#4 clock = ~clock;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// samples at the falling edge, where the combinational outputs have settled.
	task automatic wait_for_ready(input int index, output int cycles);
		cycles = 0;
		@(negedge clock);
		while (ready !== 1'b1) begin
			if (cycles >= READY_TIMEOUT) begin
				$display("the FPU gave no ready within %0d cycles on case %0d",
					READY_TIMEOUT, index);
				$display("Simulation failed");
				$fatal(1, "ready timeout");
			end else begin
				cycles++;
				@(negedge clock);
			end
		end
	endtask

	// move and the sign ops answer in the request cycle itself.
	function automatic logic is_immediate(fpu_op_t code);
		return code inside {FPU_OP_MOV, FPU_OP_SGNJ, FPU_OP_SGNJN, FPU_OP_SGNJX};
	endfunction

	function automatic int count_cases();
		int n;
		n = 0;
		while (n < MAX_CASES && case_words[4*n] !== 'x) begin
			n++;
		end
		return n;
	endfunction

	task automatic run_case(input int index);
		int cycles;
		float_t expected;
		@(posedge clock);
		#DRIVE_DELAY;
		op = fpu_op_t'(case_words[4*index][4:0]);
		op1 = case_words[4*index+1];
		op2 = case_words[4*index+2];
		expected = case_words[4*index+3];
		request = 1'b1;
		wait_for_ready(index, cycles);
		check_value("o_result", result, expected);
		check_value("o_ready in request cycle", cycles == 0, is_immediate(op));

		// the unit must hold its answer while the request stays up one more cycle.
		@(posedge clock);
		@(negedge clock);
		check_value("o_ready held", ready, 1'b1);
		check_value("o_result held", result, expected);

		@(posedge clock);
		#DRIVE_DELAY;
		request = 1'b0;
		@(negedge clock);
		check_value("o_ready after request drop", ready, 1'b0);
	endtask

	initial begin
		reset = 1'b1;
		request = 1'b0;
		op = FPU_OP_ADD;
		op1 = '0;
		op2 = '0;
		$readmemh("tests/fpu_cases.hex", case_words);
		case_count = count_cases();

		repeat (3) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(negedge clock);
		check_value("o_ready after reset", ready, 1'b0);

		if (case_count == 0) begin
			$display("no cases were read from tests/fpu_cases.hex");
			$display("Simulation failed");
			$fatal(1, "empty case file");
		end

		for (int n = 0; n < case_count; n++) begin
			run_case(n);
		end

		repeat (2) @(posedge clock);
		if (u_fpu.u_fpu_asserts.fail_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("%0d handshake assertions failed", u_fpu.u_fpu_asserts.fail_count);
			$display("Simulation failed");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// ==== fpu.f ====
logic/fpu_pkg.sv
logic/fpu_add.sv
logic/fpu_mul.sv
logic/fpu.sv
tests/fpu_asserts.sv
tests/fpu_tb.sv

// ==== tests/fpu_cases.hex ====
// columns: op code, operand 1, operand 2, expected result, all in hex.
// op codes: 00 add, 01 sub, 02 mul, 03 mov, 04 eq, 05 lt, 06 le,
// 07 sgnj, 08 sgnjn, 09 sgnjx, 0a min, 0b max.

// add and subtract, mantissas truncated.
00 3f800000 40000000 40400000
00 3fc00000 3fc00000 40400000
00 41200000 3ec00000 41260000
00 3f800001 3f800002 40000001
00 3f800000 33800000 3f800000
00 c0200000 40200000 00000000
01 40a00000 3fa00000 40700000
01 3f800000 40400000 c0000000
01 40200000 40200000 00000000

// multiply.
02 40000000 40400000 40c00000
02 3fc00000 3fc00000 40100000
02 00000000 40400000 00000000
02 c0400000 00000000 00000000
02 c0000000 40400000 c0c00000
02 bfc00000 c0200000 40700000
02 3f800001 3f800001 3f800002

// compares, answer in bit 0.
04 40200000 40200000 00000001
04 3f800000 40000000 00000000
05 3f800000 40000000 00000001
05 40000000 3f800000 00000000
05 40200000 40200000 00000000
06 40200000 40200000 00000001
06 40400000 bf800000 00000000
06 c0400000 3f800000 00000001

// min and max on mixed signs.
0a c0000000 3f800000 c0000000
0b c0000000 3f800000 3f800000
0a 40a00000 bfa00000 bfa00000
0b 40a00000 bfa00000 40a00000

// move and sign injection.
03 40490fdb bf800000 40490fdb
07 40490fdb bf800000 c0490fdb
08 40490fdb bf800000 40490fdb
08 c0490fdb 3f800000 c0490fdb
09 c0490fdb bf800000 40490fdb
09 40490fdb bf800000 c0490fdb
